//--- flist.f
verilog/mem_pkg.sv
verilog/comb_mem_d1.sv
verilog/seq_mem_d2.sv
verilog/mem_top.sv
tb/mem_asserts.sv
tb/mem_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory testbench with Verilator.
# The exit status is the simulator's own: a $fatal gives a failing status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module mem_tb \
  -Mdir obj_dir \
  -o mem_tb_sim \
  -f flist.f

./obj_dir/mem_tb_sim

//--- tb/mem_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks shared by both memories
// en is content_en on the banked memory and write_en on the scratch memory
module mem_asserts #(
  parameter int A0_W    = 1,
  parameter int A1_W    = 1,
  parameter int D0_SIZE = 1,
  parameter int D1_SIZE = 1
) (
  input wire logic            clk,
  input wire logic            reset,
  input wire logic [A0_W-1:0] addr0,
  input wire logic [A1_W-1:0] addr1,
  input wire logic            en,
  input wire logic            done
);

  // Every enabled access stays inside the configured geometry
  addr_in_range: assert property (@(posedge clk) disable iff (reset)
    en |-> (int'(addr0) < D0_SIZE) && (int'(addr1) < D1_SIZE))
    else $error("access outside the configured memory size");

  // done answers each enabled cycle one cycle later
  done_after_en: assert property (@(posedge clk) disable iff (reset)
    en |=> done)
    else $error("done missing one cycle after an enabled cycle");

  // and stays low when nothing was enabled
  done_only_after_en: assert property (@(posedge clk) disable iff (reset)
    !en |=> !done)
    else $error("done raised without an enabled cycle");

endmodule

bind seq_mem_d2 mem_asserts #(
  .A0_W    ($bits(mem_pkg::seq_d0_idx_t)),
  .A1_W    ($bits(mem_pkg::seq_d1_idx_t)),
  .D0_SIZE (D0_SIZE),
  .D1_SIZE (D1_SIZE)
) seq_asserts_i (
  .clk   (clk),
  .reset (reset),
  .addr0 (addr0),
  .addr1 (addr1),
  .en    (content_en),
  .done  (done)
);

// Scratch memory is one-dimensional, so the column is tied to zero
bind comb_mem_d1 mem_asserts #(
  .A0_W    ($bits(mem_pkg::comb_idx_t)),
  .A1_W    (1),
  .D0_SIZE (SIZE),
  .D1_SIZE (1)
) comb_asserts_i (
  .clk   (clk),
  .reset (reset),
  .addr0 (addr0),
  .addr1 (1'b0),
  .en    (write_en),
  .done  (done)
);

`default_nettype wire

//--- tb/mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_tb;
  import mem_pkg::*;

  localparam int RAND_SEED   = 28261;
  localparam int RAND_CYCLES = 1000;
  // Reset, both fills and readbacks, hold and random traffic
  // come to about 1,250 cycles, so this leaves a wide margin
  localparam int MAX_CYCLES  = 4000;

  logic        clk = 1'b0;
  logic        reset;

  comb_idx_t   comb_addr0;
  data_t       comb_write_data;
  logic        comb_write_en;
  data_t       comb_read_data;
  logic        comb_done;

  seq_d0_idx_t seq_addr0;
  seq_d1_idx_t seq_addr1;
  logic        seq_content_en;
  logic        seq_write_en;
  data_t       seq_write_data;
  data_t       seq_read_data;
  logic        seq_done;

  // Shadow model of both memories
  data_t                comb_shadow [COMB_SIZE];
  logic [COMB_SIZE-1:0] comb_written = '0;
  data_t                seq_shadow [SEQ_D0_SIZE][SEQ_D1_SIZE];
  logic                 comb_done_exp;
  logic                 seq_done_exp;
  data_t                seq_rd_exp;
  logic                 seq_rd_valid = 1'b0;
  logic                 primed = 1'b0;

  string                test_name;
  int                   cycle_count = 0;

  mem_top mem_top_i (
    .clk             (clk),
    .reset           (reset),
    .comb_addr0      (comb_addr0),
    .comb_write_data (comb_write_data),
    .comb_write_en   (comb_write_en),
    .comb_read_data  (comb_read_data),
    .comb_done       (comb_done),
    .seq_addr0       (seq_addr0),
    .seq_addr1       (seq_addr1),
    .seq_content_en  (seq_content_en),
    .seq_write_en    (seq_write_en),
    .seq_write_data  (seq_write_data),
    .seq_read_data   (seq_read_data),
    .seq_done        (seq_done)
  );

  always #5 clk = ~clk;

  function automatic data_t exp_comb_read(input comb_idx_t addr);
    return comb_shadow[addr];
  endfunction

  // Indexed as rows by columns, independent of any flattening
  function automatic data_t exp_seq_read(input seq_d0_idx_t row, input seq_d1_idx_t col);
    return seq_shadow[row][col];
  endfunction

  task automatic check_data(input string test, input string sig, input data_t exp,
                            input data_t act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test, sig, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_done(input string test, input string sig, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %b, actual %b", test, sig, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // One clock of stimulus on both memories
  task automatic drive_cycle(input comb_idx_t ca, input data_t cd, input logic cwe,
                             input seq_d0_idx_t sr, input seq_d1_idx_t sc,
                             input logic sen, input logic swe, input data_t sd);
    @(posedge clk);
    comb_addr0      <= ca;
    comb_write_data <= cd;
    comb_write_en   <= cwe;
    seq_addr0       <= sr;
    seq_addr1       <= sc;
    seq_content_en  <= sen;
    seq_write_en    <= swe;
    seq_write_data  <= sd;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle('0, '0, 1'b0, '0, '0, 1'b0, 1'b0, '0);
    end
  endtask

  // Outputs are settled at the falling edge; check them, then
  // advance the model by what the next rising edge will do
  always @(negedge clk) begin
    if (primed) begin
      if (comb_written[comb_addr0]) begin
        check_data(test_name, "comb_read_data", exp_comb_read(comb_addr0), comb_read_data);
      end
      check_done(test_name, "comb_done", comb_done_exp, comb_done);
      check_done(test_name, "seq_done", seq_done_exp, seq_done);
      if (seq_rd_valid) begin
        check_data(test_name, "seq_read_data", seq_rd_exp, seq_read_data);
      end
    end
    if (reset) begin
      comb_done_exp = 1'b0;
      seq_done_exp  = 1'b0;
      seq_rd_exp    = '0;
      seq_rd_valid  = 1'b1;
      primed        = 1'b1;
    end else begin
      comb_done_exp = comb_write_en;
      if (comb_write_en) begin
        comb_shadow[comb_addr0]  = comb_write_data;
        comb_written[comb_addr0] = 1'b1;
      end
      seq_done_exp = seq_content_en;
      if (seq_content_en && seq_write_en) begin
        seq_shadow[seq_addr0][seq_addr1] = seq_write_data;
        // Read output is unspecified after a write
        seq_rd_valid = 1'b0;
      end else if (seq_content_en) begin
        seq_rd_exp   = exp_seq_read(seq_addr0, seq_addr1);
        seq_rd_valid = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("RESULT: FAIL");
      $fatal(1, "timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  initial begin
    void'($urandom(RAND_SEED));
    test_name       = "reset";
    reset           = 1'b1;
    comb_addr0      = '0;
    comb_write_data = '0;
    comb_write_en   = 1'b0;
    seq_addr0       = '0;
    seq_addr1       = '0;
    seq_content_en  = 1'b0;
    seq_write_en    = 1'b0;
    seq_write_data  = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    idle_cycles(2);

    test_name = "scratch";
    for (int a = 0; a < COMB_SIZE; a++) begin
      drive_cycle(comb_idx_t'(a), data_t'($urandom()), 1'b1, '0, '0, 1'b0, 1'b0, '0);
    end
    for (int a = 0; a < COMB_SIZE; a++) begin
      drive_cycle(comb_idx_t'(a), '0, 1'b0, '0, '0, 1'b0, 1'b0, '0);
    end

    test_name = "banked";
    for (int r = 0; r < SEQ_D0_SIZE; r++) begin
      for (int c = 0; c < SEQ_D1_SIZE; c++) begin
        drive_cycle('0, '0, 1'b0, seq_d0_idx_t'(r), seq_d1_idx_t'(c), 1'b1, 1'b1,
                    data_t'($urandom()));
      end
    end
    // Back-to-back reads
    for (int r = 0; r < SEQ_D0_SIZE; r++) begin
      for (int c = 0; c < SEQ_D1_SIZE; c++) begin
        drive_cycle('0, '0, 1'b0, seq_d0_idx_t'(r), seq_d1_idx_t'(c), 1'b1, 1'b0, '0);
      end
    end

    // Out-of-range columns appear on the port, but never enabled
    test_name = "hold";
    for (int i = 0; i < 8; i++) begin
      drive_cycle('0, '0, 1'b0, seq_d0_idx_t'(i), seq_d1_idx_t'(SEQ_D1_SIZE + i % 4),
                  1'b0, 1'b0, data_t'($urandom()));
    end

    test_name = "random";
    for (int i = 0; i < RAND_CYCLES; i++) begin
      drive_cycle(comb_idx_t'($urandom()), data_t'($urandom()), 1'($urandom()),
                  seq_d0_idx_t'($urandom_range(SEQ_D0_SIZE - 1, 0)),
                  seq_d1_idx_t'($urandom_range(SEQ_D1_SIZE - 1, 0)),
                  1'($urandom()), 1'($urandom()), data_t'($urandom()));
    end
    idle_cycles(3);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/comb_mem_d1.sv
`timescale 1ns/1ps
`default_nettype none

// Scratch memory
// One-dimensional word array with an asynchronous read port
// and a synchronous write port sharing one address.
// done pulses in the cycle after every write cycle.
module comb_mem_d1 #(
  parameter int SIZE = mem_pkg::COMB_SIZE
) (
  input  wire logic               clk,
  input  wire logic               reset,

  // Shared read and write address
  input  wire mem_pkg::comb_idx_t addr0,

  // Write port
  input  wire mem_pkg::data_t     write_data,
  input  wire logic               write_en,

  // Read port and completion
  output mem_pkg::data_t          read_data,
  output logic                    done
);
  import mem_pkg::*;

  // Storage, contents survive reset
  data_t mem [SIZE];

  logic  wr_fire;

  // No write can land while reset is held
  assign wr_fire = write_en && !reset;

  // Combinational read of the addressed word
  // A word stored at an edge shows up right after that edge
  assign read_data = mem[addr0];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[addr0] <= write_data;
    end
  end

  // Remember whether the previous cycle wrote
  // back-to-back writes keep done high
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= write_en;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Word width shared by both memories
  localparam int DATA_WIDTH = 32;

  typedef logic [DATA_WIDTH-1:0] data_t;

  // Scratch memory geometry
  localparam int COMB_SIZE = 16;

  // Address of one scratch word
  typedef logic [$clog2(COMB_SIZE)-1:0] comb_idx_t;

  // Banked memory geometry, rows by columns
  localparam int SEQ_D0_SIZE = 8;
  localparam int SEQ_D1_SIZE = 12;

  // Row index
  typedef logic [$clog2(SEQ_D0_SIZE)-1:0] seq_d0_idx_t;

  // Column index, 4 bits for 12 columns
  // so codes 12 to 15 are representable and can reach the ports
  typedef logic [$clog2(SEQ_D1_SIZE)-1:0] seq_d1_idx_t;

  // Row-major linear index into the flat banked array
  typedef logic [$clog2(SEQ_D0_SIZE * SEQ_D1_SIZE)-1:0] seq_lin_idx_t;

endpackage

`default_nettype wire

//--- verilog/mem_top.sv
`timescale 1ns/1ps
`default_nettype none

// Memory block top level
// Two independent memories behind one clock and reset:
//   u_comb  scratch memory, combinational read
//   u_seq   banked 2-D memory, registered read
// Geometry comes from the package and is handed down here.
// No logic sits between the ports and the memories, so the
// timing at these ports is exactly that of each memory.
module mem_top (
  input  wire logic                 clk,
  input  wire logic                 reset,

  // Scratch memory
  input  wire mem_pkg::comb_idx_t   comb_addr0,
  input  wire mem_pkg::data_t       comb_write_data,
  input  wire logic                 comb_write_en,
  output mem_pkg::data_t            comb_read_data,
  output logic                      comb_done,

  // Banked memory
  input  wire mem_pkg::seq_d0_idx_t seq_addr0,
  input  wire mem_pkg::seq_d1_idx_t seq_addr1,
  input  wire logic                 seq_content_en,
  input  wire logic                 seq_write_en,
  input  wire mem_pkg::data_t       seq_write_data,
  output mem_pkg::data_t            seq_read_data,
  output logic                      seq_done
);
  import mem_pkg::*;

  // Internal nets between the ports and the instances
  data_t comb_rdata;
  logic  comb_wdone;
  data_t seq_rdata;
  logic  seq_adone;

  // Scratch memory, one word per address
  comb_mem_d1 #(
    .SIZE       (COMB_SIZE)
  ) u_comb (
    .clk        (clk),
    .reset      (reset),
    .addr0      (comb_addr0),
    .write_data (comb_write_data),
    .write_en   (comb_write_en),
    .read_data  (comb_rdata),
    .done       (comb_wdone)
  );

  // Banked memory, rows by columns
  seq_mem_d2 #(
    .D0_SIZE    (SEQ_D0_SIZE),
    .D1_SIZE    (SEQ_D1_SIZE)
  ) u_seq (
    .clk        (clk),
    .reset      (reset),
    .addr0      (seq_addr0),
    .addr1      (seq_addr1),
    .content_en (seq_content_en),
    .write_en   (seq_write_en),
    .write_data (seq_write_data),
    .read_data  (seq_rdata),
    .done       (seq_adone)
  );

  // Scratch results out
  assign comb_read_data = comb_rdata;
  assign comb_done      = comb_wdone;

  // Banked results out
  assign seq_read_data  = seq_rdata;
  assign seq_done       = seq_adone;

endmodule

`default_nettype wire

//--- verilog/seq_mem_d2.sv
`timescale 1ns/1ps
`default_nettype none

// Banked memory
// Two-dimensional word array stored flat in row-major order.
// One access per cycle with content_en high:
//   write_en high  stores write_data, read_data goes unknown
//   write_en low   loads the addressed word into read_data
// read_data holds between accesses and done follows content_en
// by exactly one cycle.
module seq_mem_d2 #(
  parameter int D0_SIZE = mem_pkg::SEQ_D0_SIZE,
  parameter int D1_SIZE = mem_pkg::SEQ_D1_SIZE
) (
  input  wire logic                 clk,
  input  wire logic                 reset,

  // Row and column of the access
  input  wire mem_pkg::seq_d0_idx_t addr0,
  input  wire mem_pkg::seq_d1_idx_t addr1,

  // Access control
  input  wire logic                 content_en,
  input  wire logic                 write_en,

  // Write payload
  input  wire mem_pkg::data_t       write_data,

  // Registered read result and completion
  output mem_pkg::data_t            read_data,
  output logic                      done
);
  import mem_pkg::*;

  // Total words in the flat array
  localparam int DEPTH = D0_SIZE * D1_SIZE;

  // Flat storage, no reset on contents
  data_t        mem [DEPTH];

  seq_lin_idx_t lin_idx;
  seq_lin_idx_t row_base;
  logic         rd_access;
  logic         wr_access;

  // Row-major linearization
  // row start = addr0 * D1_SIZE, then step by column
  assign row_base = seq_lin_idx_t'(addr0) * seq_lin_idx_t'(D1_SIZE);
  assign lin_idx  = row_base + seq_lin_idx_t'(addr1);

  // Decode the enabled access
  assign rd_access = content_en && !write_en;
  assign wr_access = content_en && write_en;

  // Output register
  // A write makes the previous read result stale, so it is
  // driven unknown until the next read refills it
  always_ff @(posedge clk) begin
    if (reset) begin
      read_data <= '0;
    end else if (rd_access) begin
      read_data <= mem[lin_idx];
    end else if (wr_access) begin
      read_data <= 'x;
    end
  end

  // Write port, held off while reset is high
  always_ff @(posedge clk) begin
    if (!reset && wr_access) begin
      mem[lin_idx] <= write_data;
    end
  end

  // One-cycle completion for every enabled cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= content_en;
    end
  end

endmodule

`default_nettype wire
